// File: filelist.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
stage_reg.sv
regfile.sv
stage_decode.sv
forward_unit.sv
stage_execute.sv
pipeline.sv
tb_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# build the pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module tb_pipeline \
    -Mdir obj_dir -o sim_pipeline \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_pipeline > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

// File: tb_pipeline.sv
/*
 * testbench for the integer pipeline
 * table of words with expected commits, random input gaps and back-pressure
 */
`timescale 1ns/1ns

module tb_pipeline
    import pipe_pkg::*;
();

    localparam int   WAIT_LIMIT = 200;   // cycles per wait loop
    localparam int   RUN_LIMIT  = 5000;  // whole run
    localparam logic LOOSE = 1'b0;       // random gap allowed before the word
    localparam logic TIGHT = 1'b1;       // back to back with the previous word
    localparam int   FN_ADD  = 0;
    localparam int   FN_SLL  = 1;
    localparam int   FN_SLT  = 2;
    localparam int   FN_SLTU = 3;
    localparam int   FN_XOR  = 4;
    localparam int   FN_OR   = 6;
    localparam int   FN_AND  = 7;
    localparam int   SUB7 = 32;          // funct7 of sub

    typedef struct packed {
        logic [31:0] word;
        logic        tight;
        commit_t     exp;
    } vector_t;

    logic    clock;
    logic    reset;
    logic    inst_valid;
    fetch_t  inst;
    logic    inst_ready;
    logic    commit_valid;
    commit_t commit;
    logic    commit_ready;

    vector_t vectors[$];
    int      accept_cycle[$];     // edge count at each input handshake
    int      cycle = 0;
    int      n_commits = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;
    int      timeouts = 0;
    logic    driver_done = 1'b0;

    pipeline u_dut (
        .clock(clock), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
        .commit_valid(commit_valid), .commit(commit), .commit_ready(commit_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1; // edge counter for latency

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////
    function automatic logic [31:0] r_word(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input int imm, input int rs1, input int f3,
                                           input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] u_word(input int imm, input int rd);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    // word that must write dest with data
    task automatic expect_write(input logic [31:0] word, input logic tight, input int dest,
                                input logic [31:0] data);
        vector_t v;
        v = '0;
        v.word        = word;
        v.tight       = tight;
        v.exp.we      = 1'b1;
        v.exp.dest    = dest[4:0];
        v.exp.data    = data;
        vectors.push_back(v);
    endtask

    // x0 destination or illegal word leaves the regfile alone
    task automatic expect_no_write(input logic [31:0] word, input logic tight,
                                   input logic illegal);
        vector_t v;
        v = '0;
        v.word        = word;
        v.tight       = tight;
        v.exp.dest    = word[11:7];
        v.exp.illegal = illegal;
        vectors.push_back(v);
    endtask

    task automatic build_vectors();
        // immediate ops and lui
        expect_write(i_word(100, 0, FN_ADD, 1), LOOSE, 1, 32'h0000_0064);   // x1 = 100
        expect_write(i_word(-7, 0, FN_ADD, 2), LOOSE, 2, 32'hffff_fff9);    // x2 = -7
        expect_write(i_word(12'h0f0, 1, FN_AND, 3), LOOSE, 3, 32'h0000_0060);
        expect_write(i_word(12'h703, 1, FN_OR, 4), LOOSE, 4, 32'h0000_0767);
        expect_write(i_word(-1, 1, FN_XOR, 5), LOOSE, 5, 32'hffff_ff9b);    // ~x1
        expect_write(i_word(-5, 2, FN_SLT, 6), LOOSE, 6, 32'h0000_0001);    // -7 < -5
        expect_write(i_word(-5, 1, FN_SLT, 7), LOOSE, 7, 32'h0000_0000);    // signed
        expect_write(u_word(20'habcde, 8), LOOSE, 8, 32'habcd_e000);
        // register ops
        expect_write(r_word(0, 2, 1, FN_ADD, 9), LOOSE, 9, 32'h0000_005d);  // x1 + x2
        expect_write(r_word(SUB7, 1, 2, FN_ADD, 10), LOOSE, 10, 32'hffff_ff95); // x2 - x1
        expect_write(r_word(0, 5, 4, FN_AND, 11), LOOSE, 11, 32'h0000_0703);
        expect_write(r_word(0, 8, 3, FN_OR, 12), LOOSE, 12, 32'habcd_e060);
        expect_write(r_word(0, 3, 4, FN_XOR, 13), LOOSE, 13, 32'h0000_0707);
        expect_write(r_word(0, 1, 8, FN_SLT, 14), LOOSE, 14, 32'h0000_0001); // negative x8
        expect_write(r_word(0, 2, 1, FN_SLT, 15), LOOSE, 15, 32'h0000_0000);
        // forwarding distances
        expect_write(i_word(5, 0, FN_ADD, 16), LOOSE, 16, 32'h0000_0005);
        expect_write(r_word(0, 16, 16, FN_ADD, 17), TIGHT, 17, 32'h0000_000a); // from execute
        expect_write(i_word(3, 0, FN_ADD, 18), TIGHT, 18, 32'h0000_0003);
        expect_write(r_word(SUB7, 16, 17, FN_ADD, 19), TIGHT, 19, 32'h0000_0005); // ex_mem
        expect_write(r_word(0, 17, 18, FN_ADD, 20), TIGHT, 20, 32'h0000_000d); // bypass
        // nearer of two x21 producers wins
        expect_write(i_word(1, 0, FN_ADD, 21), LOOSE, 21, 32'h0000_0001);
        expect_write(i_word(2, 0, FN_ADD, 21), TIGHT, 21, 32'h0000_0002);
        expect_write(i_word(0, 21, FN_ADD, 22), TIGHT, 22, 32'h0000_0002);
        expect_write(i_word(7, 0, FN_ADD, 21), TIGHT, 21, 32'h0000_0007);
        expect_write(i_word(11, 0, FN_ADD, 21), TIGHT, 21, 32'h0000_000b);
        expect_write(i_word(9, 0, FN_ADD, 23), TIGHT, 23, 32'h0000_0009);
        expect_write(r_word(0, 21, 21, FN_OR, 24), TIGHT, 24, 32'h0000_000b);
        // x0 as destination is never a forwarding source
        expect_no_write(i_word(55, 0, FN_ADD, 0), LOOSE, 1'b0);
        expect_no_write(r_word(0, 1, 1, FN_ADD, 0), TIGHT, 1'b0);
        expect_write(r_word(0, 1, 0, FN_ADD, 25), TIGHT, 25, 32'h0000_0064);
        expect_write(i_word(12, 0, FN_ADD, 26), TIGHT, 26, 32'h0000_000c);
        // illegal words leave the old value
        expect_no_write(r_word(0, 1, 1, FN_SLL, 9), LOOSE, 1'b1);           // sll
        expect_no_write(32'hffff_ffff, TIGHT, 1'b1);
        expect_write(i_word(0, 9, FN_ADD, 27), TIGHT, 27, 32'h0000_005d);   // old x9
        expect_no_write(i_word(1, 1, FN_SLL, 1), LOOSE, 1'b1);              // slli
        expect_write(r_word(0, 0, 1, FN_ADD, 28), TIGHT, 28, 32'h0000_0064);
        expect_no_write(i_word(5, 2, FN_SLTU, 2), LOOSE, 1'b1);             // sltiu
        expect_no_write(r_word(SUB7, 1, 2, FN_AND, 3), TIGHT, 1'b1);
        expect_write(r_word(0, 3, 2, FN_ADD, 29), TIGHT, 29, 32'h0000_0059); // -7 + 0x60
        // mixed chain
        expect_write(u_word(1, 30), LOOSE, 30, 32'h0000_1000);
        expect_write(i_word(-1, 30, FN_ADD, 30), TIGHT, 30, 32'h0000_0fff);
        expect_write(r_word(0, 30, 10, FN_SLT, 31), TIGHT, 31, 32'h0000_0001);
        expect_write(r_word(0, 5, 31, FN_XOR, 31), TIGHT, 31, 32'hffff_ff9a);
    endtask

    //////////////////////////////////////////////////
    // commit checking
    //////////////////////////////////////////////////
    task automatic check_commit(input int idx, input commit_t got, input int at_cycle);
        commit_t exp;
        int      latency;
        exp = vectors[idx].exp;
        if (idx >= accept_cycle.size()) begin
            $display("commit %0d arrived before its word was accepted", idx);
            protocol_errors++;
            return;
        end
        latency = at_cycle - accept_cycle[idx];
        assert (got.we == exp.we) else begin
            $display("ERROR t=%0t commit.we [%0d] got %0b expected %0b",
                     $time, idx, got.we, exp.we);
            value_errors++;
        end
        assert (got.illegal == exp.illegal) else begin
            $display("ERROR t=%0t commit.illegal [%0d] got %0b expected %0b",
                     $time, idx, got.illegal, exp.illegal);
            value_errors++;
        end
        if (exp.we) begin // dest and data only matter for a write
            assert (got.dest == exp.dest) else begin
                $display("ERROR t=%0t commit.dest [%0d] got %0d expected %0d",
                         $time, idx, got.dest, exp.dest);
                value_errors++;
            end
            assert (got.data == exp.data) else begin
                $display("ERROR t=%0t commit.data [%0d] got %h expected %h",
                         $time, idx, got.data, exp.data);
                value_errors++;
            end
        end
        if (idx == 0) begin
            assert (latency == 4) else begin
                $display("ERROR t=%0t latency [0] got %0d expected 4", $time, latency);
                value_errors++;
            end
        end else begin
            assert (latency >= 4) else begin
                $display("commit %0d came only %0d edges after acceptance", idx, latency);
                protocol_errors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // input stream
    //////////////////////////////////////////////////
    initial begin : drive_inputs
        int waited;
        int gap;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (reset && waited < WAIT_LIMIT);
        for (int i = 0; i < vectors.size() && timeouts == 0; i++) begin
            if (i > 0 && !vectors[i].tight && ($urandom % 3) == 0) begin
                gap = 1 + ($urandom % 3); // idle cycles
                inst_valid <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            inst       <= vectors[i].word;
            inst_valid <= 1'b1;
            waited = 0;
            do begin
                @(posedge clock);
                waited++;
            end while (!inst_ready && waited < WAIT_LIMIT);
            if (inst_ready) begin
                accept_cycle.push_back(cycle);
            end else begin
                $display("timeout: word %0d was never accepted", i);
                timeouts++;
            end
        end
        inst_valid  <= 1'b0;
        driver_done = 1'b1;
    end

    //////////////////////////////////////////////////
    // commit stream and back-pressure
    //////////////////////////////////////////////////
    initial begin : watch_commits
        int idle;
        idle = 0;
        do begin
            @(posedge clock);
            idle++;
        end while (reset && idle < WAIT_LIMIT);
        idle = 0;
        while (n_commits < vectors.size() && timeouts == 0) begin
            @(posedge clock);
            assert (!(commit_valid && !commit_ready) || !inst_ready) else begin
                $display("inst_ready was high while a commit was held back at t=%0t", $time);
                protocol_errors++;
            end
            if (commit_valid && commit_ready) begin
                check_commit(n_commits, commit, cycle);
                n_commits++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle >= WAIT_LIMIT) begin
                $display("timeout: no commit for %0d cycles after commit %0d",
                         WAIT_LIMIT, n_commits);
                timeouts++;
            end
            // ready held high up to the first commit for the latency check
            commit_ready <= (n_commits == 0) || (($urandom % 4) != 0);
        end
        commit_ready <= 1'b1;
    end

    initial begin : run_control
        int waited;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = 32'h0000_0013; // nop
        commit_ready = 1'b0;          // empty pipe alone must raise inst_ready
        void'($urandom(32'hcc93_2f80));
        build_vectors();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        assert (commit_valid == 1'b0) else begin
            $display("ERROR t=%0t commit_valid got %0b expected 0", $time, commit_valid);
            value_errors++;
        end
        assert (inst_ready == 1'b1) else begin
            $display("ERROR t=%0t inst_ready got %0b expected 1", $time, inst_ready);
            value_errors++;
        end
        waited = 0;
        while (!(driver_done && n_commits == vectors.size()) && timeouts == 0
               && waited < RUN_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (waited >= RUN_LIMIT) begin
            $display("timeout: run did not finish in %0d cycles", RUN_LIMIT);
            timeouts++;
        end
        if (timeouts == 0) begin
            repeat (8) begin // drained pipe stays quiet
                @(posedge clock);
                assert (!commit_valid) else begin
                    $display("extra commit after the last table entry at t=%0t", $time);
                    protocol_errors++;
                end
            end
        end
        $display("errors value=%0d protocol=%0d timeout=%0d commits=%0d/%0d",
                 value_errors, protocol_errors, timeouts, n_commits, vectors.size());
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: pipeline.sv
/*
 * four-register in-order integer pipeline
 * if_id, id_ex, ex_mem, mem_wb with forwarding and writeback to the regfile
 */
`timescale 1ns/1ns
`include "riscv_defines.svh"

module pipeline
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    inst_valid,
    input  fetch_t  inst,
    output logic    inst_ready,
    output logic    commit_valid,
    output commit_t commit,
    input  logic    commit_ready
);

    //////////////////////////////////////////////////
    // wires
    //////////////////////////////////////////////////
    logic             advance;       // whole pipe moves together
    logic             if_id_valid;
    fetch_t           if_id_q;
    decode_t          dec;
    decode_t          id_ex_in;
    decode_t          id_ex_q;
    logic             id_ex_valid;
    result_t          ex_res;
    result_t          ex_mem_q;
    logic             ex_mem_valid;
    result_t          mem_wb_q;
    logic             mem_wb_valid;
    logic [`XLEN-1:0] rf_rs1;
    logic [`XLEN-1:0] rf_rs2;
    logic [`XLEN-1:0] fwd_rs1;
    logic [`XLEN-1:0] fwd_rs2;
    logic             wb_en;

    // stall only when a real commit is refused
    assign advance    = commit_ready || !mem_wb_valid;
    assign inst_ready = advance;

    //////////////////////////////////////////////////
    // fetch / decode
    //////////////////////////////////////////////////
    stage_reg #(.payload_t(fetch_t)) u_if_id (
        .clock(clock), .reset(reset), .en(advance),
        .in_valid(inst_valid), .in_data(inst),
        .out_valid(if_id_valid), .out_data(if_id_q)
    );

    stage_decode u_decode (
        .word(if_id_q), .word_valid(if_id_valid),
        .rf_rs1_data(rf_rs1), .rf_rs2_data(rf_rs2),
        .dec(dec)
    );

    regfile u_regfile (
        .clock(clock), .reset(reset),
        .rd1_idx(dec.rs1_idx), .rd2_idx(dec.rs2_idx),
        .rd1_data(rf_rs1), .rd2_data(rf_rs2),
        .wr_en(wb_en), .wr_idx(mem_wb_q.dest), .wr_data(mem_wb_q.data)
    );

    forward_unit u_forward (
        .dec(dec),
        .ex_valid(id_ex_valid), .ex_res(ex_res),
        .mem_valid(ex_mem_valid), .mem_res(ex_mem_q),
        .rs1_val(fwd_rs1), .rs2_val(fwd_rs2)
    );

    // forwarded operands replace the regfile reads
    always_comb begin
        id_ex_in          = dec;
        id_ex_in.rs1_data = fwd_rs1;
        id_ex_in.rs2_data = fwd_rs2;
    end

    //////////////////////////////////////////////////
    // execute / mem
    //////////////////////////////////////////////////
    stage_reg #(.payload_t(decode_t)) u_id_ex (
        .clock(clock), .reset(reset), .en(advance),
        .in_valid(if_id_valid), .in_data(id_ex_in),
        .out_valid(id_ex_valid), .out_data(id_ex_q)
    );

    stage_execute u_execute (
        .dec(id_ex_q),
        .rs1_val(id_ex_q.rs1_data), .rs2_val(id_ex_q.rs2_data),
        .res(ex_res)
    );

    stage_reg #(.payload_t(result_t)) u_ex_mem (
        .clock(clock), .reset(reset), .en(advance),
        .in_valid(id_ex_valid), .in_data(ex_res),
        .out_valid(ex_mem_valid), .out_data(ex_mem_q)
    );

    // mem stage has no logic left, only its register
    stage_reg #(.payload_t(result_t)) u_mem_wb (
        .clock(clock), .reset(reset), .en(advance),
        .in_valid(ex_mem_valid), .in_data(ex_mem_q),
        .out_valid(mem_wb_valid), .out_data(mem_wb_q)
    );

    //////////////////////////////////////////////////
    // writeback / commit
    //////////////////////////////////////////////////
    assign wb_en = mem_wb_valid && mem_wb_q.we && advance; // write on commit handshake

    assign commit_valid = mem_wb_valid;
    assign commit = '{
        we:      mem_wb_q.we,
        dest:    mem_wb_q.dest,
        data:    mem_wb_q.data,
        illegal: mem_wb_q.illegal
    };

endmodule

// File: stage_execute.sv
/*
 * execute stage
 * operand b select and alu, builds the ex_mem result packet
 */
`timescale 1ns/1ns
`include "riscv_defines.svh"

module stage_execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  decode_t          dec,
    input  logic [`XLEN-1:0] rs1_val,  // already forwarded
    input  logic [`XLEN-1:0] rs2_val,
    output result_t          res
);

    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] alu_out;
    logic             lt;

    assign opb = (dec.opb_sel == OPB_IMM) ? dec.imm : rs2_val;
    assign lt  = $signed(rs1_val) < $signed(opb); // slt / slti are signed

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_out = rs1_val + opb;
            ALU_SUB:    alu_out = rs1_val - opb;
            ALU_AND:    alu_out = rs1_val & opb;
            ALU_OR:     alu_out = rs1_val | opb;
            ALU_XOR:    alu_out = rs1_val ^ opb;
            ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, lt};
            ALU_PASS_B: alu_out = opb; // lui immediate
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        res         = '0;
        res.we      = dec.we;
        res.dest    = dec.dest;
        res.data    = alu_out;
        res.illegal = dec.illegal;
    end

endmodule

// File: forward_unit.sv
/*
 * operand forwarding
 * picks each source from execute, ex_mem or the regfile, nearest first
 */
`timescale 1ns/1ns
`include "riscv_defines.svh"

module forward_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  decode_t          dec,
    input  logic             ex_valid,   // id_ex holds a real instruction
    input  result_t          ex_res,     // comb execute result
    input  logic             mem_valid,
    input  result_t          mem_res,    // ex_mem register
    output logic [`XLEN-1:0] rs1_val,
    output logic [`XLEN-1:0] rs2_val
);

    // producer qualifies for a given source index
    function automatic logic hit(input logic v, input result_t r, input reg_idx_t idx);
        return v && r.we && (idx != `ZERO_REG) && (r.dest == idx);
    endfunction

    always_comb begin
        // rs1, nearest older producer wins
        if (hit(ex_valid, ex_res, dec.rs1_idx)) begin
            rs1_val = ex_res.data;
        end else if (hit(mem_valid, mem_res, dec.rs1_idx)) begin
            rs1_val = mem_res.data;
        end else begin
            rs1_val = dec.rs1_data; // regfile, incl. mem_wb bypass
        end

        // rs2, same chain
        if (hit(ex_valid, ex_res, dec.rs2_idx)) begin
            rs2_val = ex_res.data;
        end else if (hit(mem_valid, mem_res, dec.rs2_idx)) begin
            rs2_val = mem_res.data;
        end else begin
            rs2_val = dec.rs2_data;
        end
    end

endmodule

// File: stage_decode.sv
/*
 * instruction decode
 * field split, immediate generation, alu op mapping, illegal detect
 */
`timescale 1ns/1ns
`include "riscv_defines.svh"

module stage_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  fetch_t           word,
    input  logic             word_valid,
    input  logic [`XLEN-1:0] rf_rs1_data,  // from regfile, indexed by dec.rs1_idx
    input  logic [`XLEN-1:0] rf_rs2_data,
    output decode_t          dec
);

    fetch_t           w;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    alu_op_t          alu_op;
    opb_sel_t         opb_sel;
    logic             use_imm_u;
    logic             illegal;

    assign w = word_valid ? word : `NOP_WORD; // bubbles decode as a harmless nop

    // fixed field positions
    assign opcode = w[6:0];
    assign funct3 = w[14:12];
    assign funct7 = w[31:25];

    assign imm_i = {{(`XLEN-12){w[31]}}, w[31:20]}; // sign extended
    assign imm_u = {w[31:12], 12'b0};

    //////////////////////////////////////////////////
    // opcode / funct to alu op
    //////////////////////////////////////////////////
    always_comb begin
        alu_op    = ALU_ADD;
        opb_sel   = OPB_RS2;
        use_imm_u = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            OP_REG: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {F7_SUB,  F3_ADD_SUB}: alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
                    default:               illegal = 1'b1; // shifts, sltu, m-ext
                endcase
            end
            OP_IMM: begin
                opb_sel = OPB_IMM;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_AND:     alu_op = ALU_AND;
                    F3_OR:      alu_op = ALU_OR;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SLT:     alu_op = ALU_SLT;
                    default:    illegal = 1'b1; // shift imm, sltiu
                endcase
            end
            OP_LUI: begin
                opb_sel   = OPB_IMM;
                use_imm_u = 1'b1;
                alu_op    = ALU_PASS_B;
            end
            default: illegal = 1'b1;
        endcase
    end

    // packet for id_ex
    always_comb begin
        dec          = '0;
        dec.rs1_idx  = w[19:15];
        dec.rs2_idx  = w[24:20];
        dec.rs1_data = rf_rs1_data;
        dec.rs2_data = rf_rs2_data;
        dec.imm      = use_imm_u ? imm_u : imm_i;
        dec.opb_sel  = opb_sel;
        dec.alu_op   = alu_op;
        dec.dest     = w[11:7];
        dec.we       = !illegal && (w[11:7] != `ZERO_REG); // x0 never written
        dec.illegal  = illegal;
    end

endmodule

// File: regfile.sv
/*
 * integer register file
 * two async read ports, one write port, x0 reads zero, write bypass
 */
`timescale 1ns/1ns
`include "riscv_defines.svh"

module regfile
    import isa_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  reg_idx_t         rd1_idx,
    input  reg_idx_t         rd2_idx,
    output logic [`XLEN-1:0] rd1_data,
    output logic [`XLEN-1:0] rd2_data,
    input  logic             wr_en,
    input  reg_idx_t         wr_idx,
    input  logic [`XLEN-1:0] wr_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // one read port with x0 and same-cycle write handling
    function automatic logic [`XLEN-1:0] read_port(input reg_idx_t idx);
        if (idx == `ZERO_REG) begin
            return '0;
        end else if (wr_en && (wr_idx == idx)) begin
            return wr_data; // bypass covers the mem_wb distance
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != `ZERO_REG)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        rd1_data = read_port(rd1_idx);
        rd2_data = read_port(rd2_idx);
    end

endmodule

// File: stage_reg.sv
/*
 * pipeline stage register
 * payload plus valid bit, held while en is low
 */
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     en,        // pipeline advance
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit, a bubble after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (en) begin
            out_valid <= in_valid; // low upstream valid loads a bubble
        end
    end

    // payload, only meaningful with out_valid
    always_ff @(posedge clock) begin
        if (en) begin
            out_data <= in_data;
        end
    end

endmodule

// File: pipe_pkg.sv
/*
 * inter-stage packets
 * payloads of the four stage registers and of the top-level streams
 */
`include "riscv_defines.svh"

package pipe_pkg;

    import isa_pkg::*;

    // raw instruction word, input stream and if_id payload
    typedef logic [31:0] fetch_t;

    // decoded instruction, id_ex payload
    typedef struct packed {
        reg_idx_t          rs1_idx;
        reg_idx_t          rs2_idx;
        logic [`XLEN-1:0]  rs1_data;  // forwarded by the time it reaches id_ex
        logic [`XLEN-1:0]  rs2_data;
        logic [`XLEN-1:0]  imm;       // i or u immediate
        opb_sel_t          opb_sel;
        alu_op_t           alu_op;
        reg_idx_t          dest;
        logic              we;        // low for x0 and illegal
        logic              illegal;
    } decode_t;

    // alu result, ex_mem and mem_wb payload
    typedef struct packed {
        logic              we;
        reg_idx_t          dest;
        logic [`XLEN-1:0]  data;
        logic              illegal;
    } result_t;

    // commit stream payload
    // same fields as result_t for now
    typedef struct packed {
        logic              we;
        reg_idx_t          dest;
        logic [`XLEN-1:0]  data;
        logic              illegal;
    } commit_t;

endpackage

// File: isa_pkg.sv
/*
 * RV32I subset encodings
 * opcode and funct codes of the kept ops, alu op and operand-b select
 */
`include "riscv_defines.svh"

package isa_pkg;

    typedef logic [`REG_IDX_W-1:0] reg_idx_t; // register index

    //////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////
    localparam logic [6:0] OP_REG = 7'b0110011; // r-type alu
    localparam logic [6:0] OP_IMM = 7'b0010011; // i-type alu
    localparam logic [6:0] OP_LUI = 7'b0110111;

    //////////////////////////////////////////////////
    // funct fields
    //////////////////////////////////////////////////
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010; // signed compare
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000; // only with add/sub funct3

    // alu operation
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // lui, operand b straight out
    } alu_op_t;

    // second alu operand source
    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_t;

endpackage

// File: riscv_defines.svh
/*
 * RV32 integer pipeline constants
 * data width, register file shape and the canonical nop encoding
 */
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// datapath
`define XLEN       32

// register file shape
`define REG_IDX_W  5
`define NUM_REGS   32
`define ZERO_REG   5'd0

// addi x0, x0, 0
`define NOP_WORD   32'h0000_0013

`endif
